// File: board_io.f
src/board_io_pkg.sv
src/input_debouncer.sv
src/event_fifo.sv
src/gpio_regs.sv
src/board_io_top.sv
tb/board_io_tb.sv

// File: Makefile
# Verilator build and run for the board I/O block.

TOP = board_io_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f board_io.f --Mdir obj_dir

# A failing run ends in $fatal, which gives a non-zero exit status.
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb/board_io_tb.sv
`timescale 1ns/100ps

module board_io_tb import board_io_pkg::*; ();

    localparam int debounce_cycles = 4;
    localparam int fifo_depth      = 4;
    localparam int settle_cycles   = 2 + debounce_cycles + 2;
    localparam int timeout_cycles  = 3000;    // Tests need about 120 cycles.

    logic              clk;
    logic              rst_n;
    logic [3:0]        sw;
    logic [1:0]        key;
    logic              hsel;
    logic [bus_w-1:0]  haddr;
    logic              hwrite;
    logic [bus_w-1:0]  hwdata;
    logic [bus_w-1:0]  hrdata;
    logic [n_leds-1:0] led;
    int                seed   = 32'h8b1e;
    int                cycles = 0;

    board_io_top #(
        .DEBOUNCE_CYCLES ( debounce_cycles ),
        .FIFO_DEPTH      ( fifo_depth      )
    ) board_io_top_i (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .sw     ( sw     ),
        .key    ( key    ),
        .hsel   ( hsel   ),
        .haddr  ( haddr  ),
        .hwrite ( hwrite ),
        .hwdata ( hwdata ),
        .hrdata ( hrdata ),
        .led    ( led    )
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("Timeout: the run went past %0d clock cycles.", timeout_cycles);
            $display("tests failed");
            $fatal(1, "simulation timed out");
        end
    end

    // Expected event word from the map. Valid in bit 31, idx in 3:1, level in 0.
    function automatic logic [31:0] event_word(input int idx, input logic level);
        return 32'h8000_0000 | (32'(idx) << 1) | 32'(level);
    endfunction

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected %h actual %h", test, expected, actual);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        hsel   = 1'b1;
        hwrite = 1'b1;
        haddr  = addr;
        hwdata = data;
        next_cycle();
        hsel   = 1'b0;
        hwrite = 1'b0;
    endtask

    // Samples mid-cycle. The pop lands on the following edge.
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        hsel   = 1'b1;
        hwrite = 1'b0;
        haddr  = addr;
        @(negedge clk);
        data = hrdata;
        next_cycle();
        hsel = 1'b0;
    endtask

    task automatic set_inputs(input logic [3:0] sw_val, input logic [1:0] key_val);
        sw  = sw_val;
        key = key_val;
    endtask

    task automatic wait_settle();
        repeat (settle_cycles) next_cycle();
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        check_value("reset led", 32'h0, 32'(led));
        bus_read(addr_switches, data);
        check_value("reset switches", 32'h0, data);
        bus_read(addr_buttons, data);
        check_value("reset buttons", 32'h0, data);
        bus_read(addr_status, data);
        check_value("reset status", 32'h0, data);
        bus_read(addr_leds, data);
        check_value("reset led register", 32'h0, data);
    endtask

    task automatic test_led_register();
        logic [31:0] pattern;
        logic [31:0] data;
        for (int i = 0; i < 4; i++) begin
            pattern = $random(seed);
            bus_write(addr_leds, pattern);
            check_value("led output", {24'h0, pattern[7:0]}, 32'(led));
            bus_read(addr_leds, data);
            check_value("led readback", {24'h0, pattern[7:0]}, data);
        end
        bus_read(32'h28, data);    // Low bits match the LED register.
        check_value("unmapped read", 32'h0, data);
    endtask

    task automatic test_switch_debounce();
        logic [31:0] data;
        set_inputs(4'b0100, 2'b11);    // Too short to pass the debouncer.
        repeat (2) next_cycle();
        set_inputs(4'b0000, 2'b11);
        wait_settle();
        bus_read(addr_switches, data);
        check_value("glitch switches", 32'h0, data);
        bus_read(addr_status, data);
        check_value("glitch status", 32'h0, data);
        set_inputs(4'b0100, 2'b11);
        wait_settle();
        bus_read(addr_switches, data);
        check_value("held switches", 32'h4, data);
        bus_read(addr_status, data);
        check_value("held status", 32'h1, data);
        bus_read(addr_event, data);
        check_value("switch event", event_word(2, 1'b1), data);
        bus_read(addr_event, data);
        check_value("empty event read", 32'h0, data);
    endtask

    task automatic test_button_polarity();
        logic [31:0] data;
        set_inputs(4'b0100, 2'b01);    // key[1] pressed.
        wait_settle();
        bus_read(addr_buttons, data);
        check_value("pressed buttons", 32'h2, data);
        bus_read(addr_event, data);
        check_value("press event", event_word(5, 1'b1), data);
        set_inputs(4'b0100, 2'b11);
        wait_settle();
        bus_read(addr_buttons, data);
        check_value("released buttons", 32'h0, data);
        bus_read(addr_event, data);
        check_value("release event", event_word(5, 1'b0), data);
    endtask

    task automatic test_queue_overflow();
        logic [31:0] data;
        logic        level;
        level = 1'b0;
        for (int i = 0; i < 6; i++) begin
            level = ~level;
            set_inputs({3'b010, level}, 2'b11);
            wait_settle();
        end
        bus_read(addr_status, data);
        check_value("full status", 32'h104, data);
        for (int i = 0; i < fifo_depth; i++) begin
            bus_read(addr_event, data);
            check_value("queued event", event_word(0, (i % 2) == 0), data);
        end
        bus_read(addr_status, data);
        check_value("drained status", 32'h100, data);
        bus_write(addr_status, 32'h100);
        bus_read(addr_status, data);
        check_value("cleared status", 32'h0, data);
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        sw     = '0;
        key    = 2'b11;
        hsel   = 1'b0;
        haddr  = '0;
        hwrite = 1'b0;
        hwdata = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_state();
        test_led_register();
        test_switch_debounce();
        test_button_polarity();
        test_queue_overflow();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: src/board_io_top.sv
`timescale 1ns/100ps

module board_io_top import board_io_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 16,
    parameter int FIFO_DEPTH      = 8
)
(
    input                   clk,
    input                   rst_n,

    input  [n_switches-1:0] sw,
    input  [n_buttons -1:0] key,    // Active low.

    input                   hsel,
    input  [bus_w     -1:0] haddr,
    input                   hwrite,
    input  [bus_w     -1:0] hwdata,
    output [bus_w     -1:0] hrdata,

    output [n_leds    -1:0] led
);

    logic [n_inputs-1:0] raw_in;
    logic [n_inputs-1:0] stable;
    logic                evt_valid;
    io_event_t           evt;
    io_event_t           rd_event;
    logic                rd_valid;
    logic [count_w -1:0] count;
    logic                overflow;
    logic                pop;
    logic                clear_overflow;

    assign raw_in = { ~ key, sw };    // Buttons read 1 when pressed.

    input_debouncer
    # (
        .WIDTH           ( n_inputs        ),
        .DEBOUNCE_CYCLES ( DEBOUNCE_CYCLES )
    )
    input_debouncer_i
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .raw_in    ( raw_in    ),
        .stable    ( stable    ),
        .evt_valid ( evt_valid ),
        .evt       ( evt       )
    );

    event_fifo
    # (.DEPTH ( FIFO_DEPTH ))
    event_fifo_i
    (
        .clk            ( clk            ),
        .rst_n          ( rst_n          ),
        .push           ( evt_valid      ),
        .wr_event       ( evt            ),
        .pop            ( pop            ),
        .clear_overflow ( clear_overflow ),
        .rd_event       ( rd_event       ),
        .rd_valid       ( rd_valid       ),
        .count          ( count          ),
        .overflow       ( overflow       )
    );

    gpio_regs gpio_regs_i
    (
        .clk            ( clk            ),
        .rst_n          ( rst_n          ),
        .hsel           ( hsel           ),
        .haddr          ( haddr          ),
        .hwrite         ( hwrite         ),
        .hwdata         ( hwdata         ),
        .hrdata         ( hrdata         ),
        .stable         ( stable         ),
        .rd_event       ( rd_event       ),
        .rd_valid       ( rd_valid       ),
        .count          ( count          ),
        .overflow       ( overflow       ),
        .pop            ( pop            ),
        .clear_overflow ( clear_overflow ),
        .led            ( led            )
    );

endmodule

// File: src/gpio_regs.sv
`timescale 1ns/100ps

module gpio_regs import board_io_pkg::*;
(
    input                       clk,
    input                       rst_n,

    input                       hsel,
    input        [bus_w-1:0]    haddr,
    input                       hwrite,
    input        [bus_w-1:0]    hwdata,
    output logic [bus_w-1:0]    hrdata,

    input        [n_inputs-1:0] stable,
    input  io_event_t           rd_event,
    input                       rd_valid,
    input        [count_w-1:0]  count,
    input                       overflow,
    output logic                pop,
    output logic                clear_overflow,

    output logic [n_leds-1:0]   led
);

    logic rd_strobe;
    logic wr_strobe;

    assign rd_strobe = hsel && !hwrite;
    assign wr_strobe = hsel &&  hwrite;

    // Pop only with data present, so an empty read is side-effect free.
    assign pop            = rd_strobe && (haddr == addr_event) && rd_valid;
    assign clear_overflow = wr_strobe && (haddr == addr_status) && hwdata[status_ovf_bit];

    always_ff @(posedge clk) begin
        if (!rst_n)
            led <= '0;
        else if (wr_strobe && haddr == addr_leds)
            led <= hwdata[n_leds-1:0];
    end

    // Read mux.
    always_comb begin
        hrdata = '0;
        case (haddr)
            addr_switches: begin
                hrdata[n_switches-1:0] = stable[n_switches-1:0];
            end
            addr_buttons: begin
                hrdata[n_buttons-1:0] = stable[n_inputs-1:n_switches];
            end
            addr_leds: begin
                hrdata[n_leds-1:0] = led;
            end
            addr_event: begin
                if (rd_valid) begin
                    hrdata[evt_valid_bit]    = 1'b1;
                    hrdata[io_event_w-1:0]   = rd_event;
                end
            end
            addr_status: begin
                hrdata[count_w-1:0]      = count;
                hrdata[status_ovf_bit]   = overflow;
            end
            default: begin
                hrdata = '0;    // Unmapped.
            end
        endcase
    end

endmodule

// File: src/event_fifo.sv
`timescale 1ns/100ps

module event_fifo import board_io_pkg::*;
#(
    parameter int DEPTH = 8
)
(
    input                      clk,
    input                      rst_n,
    input                      push,
    input  io_event_t          wr_event,
    input                      pop,
    input                      clear_overflow,
    output io_event_t          rd_event,
    output logic               rd_valid,
    output logic [count_w-1:0] count,
    output logic               overflow
);

    localparam int ptr_w = $clog2(DEPTH);

    io_event_t        mem [DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign rd_valid = count != '0;
    assign full     = count == count_w'(DEPTH);
    assign do_pop   = pop && rd_valid;
    assign do_push  = push && (!full || do_pop);    // Pop frees a slot this cycle.
    assign rd_event = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wr_event;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps since depth is a power of two.
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !do_push)
                overflow <= 1'b1;    // Dropped event.
            else if (clear_overflow)
                overflow <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) count <= count_w'(DEPTH));
    assert property (@(posedge clk) disable iff (!rst_n) pop |-> rd_valid);

endmodule

// File: src/input_debouncer.sv
`timescale 1ns/100ps

module input_debouncer import board_io_pkg::*;
#(
    parameter int WIDTH           = n_inputs,
    parameter int DEBOUNCE_CYCLES = 16
)
(
    input                    clk,
    input                    rst_n,
    input        [WIDTH-1:0] raw_in,
    output logic [WIDTH-1:0] stable,
    output logic             evt_valid,
    output io_event_t        evt
);

    localparam int cnt_w = $clog2(DEBOUNCE_CYCLES + 1);

    logic [WIDTH-1:0] sync_0;
    logic [WIDTH-1:0] sync_1;
    logic [cnt_w-1:0] cnt [WIDTH];
    logic [WIDTH-1:0] ready;
    logic             sel_found;
    logic [idx_w-1:0] sel_idx;

    // Two-flop synchronizer.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_0 <= '0;
            sync_1 <= '0;
        end else begin
            sync_0 <= raw_in;
            sync_1 <= sync_0;
        end
    end

    // Counts while the input disagrees with stable and saturates at threshold.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < WIDTH; i++)
                cnt[i] <= '0;
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                if (sync_1[i] == stable[i])
                    cnt[i] <= '0;
                else if (cnt[i] != cnt_w'(DEBOUNCE_CYCLES))
                    cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < WIDTH; i++)
            ready[i] = (sync_1[i] != stable[i]) && (cnt[i] == cnt_w'(DEBOUNCE_CYCLES));
    end

    // Lowest ready index wins.
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel_found = 1'b1;
                sel_idx   = idx_w'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stable    <= '0;
            evt_valid <= 1'b0;
        end else begin
            evt_valid <= sel_found;
            if (sel_found)
                stable[sel_idx] <= ~stable[sel_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (sel_found) begin
            evt.idx   <= sel_idx;
            evt.level <= ~stable[sel_idx];    // Level after the flip.
        end
    end

    // The event's bit is the only stable bit that moved, and it moved to the event's level.
    assert property (@(posedge clk) disable iff (!rst_n)
        evt_valid |-> (stable ^ $past(stable)) == (WIDTH'(1) << evt.idx)
            && evt.level == stable[evt.idx]);

endmodule

// File: src/board_io_pkg.sv
package board_io_pkg;

    // Board inputs.
    localparam int n_switches = 4;
    localparam int n_buttons  = 2;
    localparam int n_inputs   = n_switches + n_buttons;
    localparam int idx_w      = 3;

    localparam int n_leds     = 8;

    localparam int bus_w      = 32;
    localparam int count_w    = 8;    // FIFO occupancy field width.

    // One debounced change. Switches use indices 0..3, buttons 4..5.
    typedef struct packed {
        logic [idx_w-1:0] idx;
        logic             level;
    } io_event_t;

    localparam int io_event_w = $bits(io_event_t);

    // Register map.
    localparam logic [bus_w-1:0] addr_switches = 32'h00;
    localparam logic [bus_w-1:0] addr_buttons  = 32'h04;
    localparam logic [bus_w-1:0] addr_leds     = 32'h08;
    localparam logic [bus_w-1:0] addr_event    = 32'h0C;    // Read pops.
    localparam logic [bus_w-1:0] addr_status   = 32'h10;

    localparam int evt_valid_bit  = 31;
    localparam int status_ovf_bit = 8;

endpackage
